// ==== Makefile ====
VERILATOR    = verilator
COMMON_FLAGS = --timing
BUILD_FLAGS  = --binary -j 0
TOP          = tb_axil_monitor
FILELIST     = vlog.f
OBJ_DIR      = obj_dir
PASS_MSG     = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/axil_bus_pkg.sv ====
// AXI4-Lite channel types: response codes and one packed struct per channel
`include "axil_mon_params.svh"

package axil_bus_pkg;

	// BRESP and RRESP encodings
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axil_resp_e;

	// Write address channel
	typedef struct packed {
		logic                valid;
		logic                ready;
		logic [`AXIL_AW-1:0] addr;
	} axil_aw_t;

	// Write data channel
	typedef struct packed {
		logic                  valid;
		logic                  ready;
		logic [`AXIL_DW-1:0]   data;
		logic [`AXIL_DW/8-1:0] strb;
	} axil_w_t;

	// Write response channel
	typedef struct packed {
		logic       valid;
		logic       ready;
		axil_resp_e resp;
	} axil_b_t;

	// Read address channel
	typedef struct packed {
		logic                valid;
		logic                ready;
		logic [`AXIL_AW-1:0] addr;
	} axil_ar_t;

	// Read data channel
	typedef struct packed {
		logic                valid;
		logic                ready;
		axil_resp_e          resp;
		logic [`AXIL_DW-1:0] data;
	} axil_r_t;

	// Whole link as seen by the monitor
	typedef struct packed {
		axil_aw_t aw;
		axil_w_t  w;
		axil_b_t  b;
		axil_ar_t ar;
		axil_r_t  r;
	} axil_bus_t;

endpackage

// ==== hdl/axil_fault_log.sv ====
// Fault log: priority pick, first-code latch and saturating fault-cycle count
`timescale 1ns/1ps

module axil_fault_log
	import axil_mon_pkg::*;
(
	input  logic          i_clk,
	input  logic          i_axi_reset_n,
	input  rule_faults_t  i_rule_faults,
	input  stall_faults_t i_stall_faults,
	output logic          o_fault,
	output fault_code_e   o_fault_code,
	output logic [7:0]    o_fault_count
);

	localparam int NFLT = $bits(rule_faults_t) + $bits(stall_faults_t);

	// MSB is reset_valid, LSB is rd_delay
	logic [NFLT-1:0] flags;
	fault_code_e     pick;

	assign flags = {i_rule_faults, i_stall_faults};

	// Scan up from the LSB so the highest set bit, the earliest code, wins
	always_comb
	begin
		pick = FLT_NONE;
		for (int k = 0; k < NFLT; k++)
			if (flags[k])
				pick = fault_code_e'(5'(NFLT - k));
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_fault       <= 1'b0;
			o_fault_code  <= FLT_NONE;
			o_fault_count <= '0;
		end
		else if (|flags)
		begin
			o_fault <= 1'b1;
			// Keep the first code ever logged
			if (!o_fault)
				o_fault_code <= pick;
			if (o_fault_count != 8'hff)
				o_fault_count <= o_fault_count + 1'b1;
		end
	end

endmodule

// ==== hdl/axil_mon_params.svh ====
// AXI4-Lite monitor limits: bus widths, count width and watchdog timeouts
`ifndef AXIL_MON_PARAMS_SVH
`define AXIL_MON_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Observed bus geometry
////////////////////////////////////////////////////////////////////////////

// Address width of AW and AR
`define AXIL_AW 28

// Data width of W and R, strobe is one bit per byte
`define AXIL_DW 32

////////////////////////////////////////////////////////////////////////////
// Monitor sizing
////////////////////////////////////////////////////////////////////////////

// Width of the outstanding counts and of every watchdog counter
`define MON_LGDEPTH 4

// Cycles a request may sit with VALID high and READY low
`define MON_MAXWAIT 12
// Cycles a response may sit with VALID high and READY low
`define MON_MAXRSTALL 12
// Cycles between an accepted request and its response
`define MON_MAXDELAY 12

`endif

// ==== hdl/axil_mon_pkg.sv ====
// Monitor result types: outstanding counts, fault flag groups and fault codes
`include "axil_mon_params.svh"

package axil_mon_pkg;

	// Outstanding transactions per direction
	typedef struct packed {
		logic [`MON_LGDEPTH-1:0] awr;
		logic [`MON_LGDEPTH-1:0] wr;
		logic [`MON_LGDEPTH-1:0] rd;
	} mon_counts_t;

	// Protocol rule violations, first field is highest priority
	typedef struct packed {
		logic reset_valid;
		logic aw_unstable;
		logic w_unstable;
		logic ar_unstable;
		logic b_unstable;
		logic r_unstable;
		logic exokay;
		logic b_noreq;
		logic r_noreq;
		logic overflow;
	} rule_faults_t;

	// Watchdog timeouts, ranked below every rule fault
	typedef struct packed {
		logic aw_stall;
		logic w_stall;
		logic ar_stall;
		logic b_stall;
		logic r_stall;
		logic wr_delay;
		logic rd_delay;
	} stall_faults_t;

	// Logged code, order matches the flag fields above
	typedef enum logic [4:0] {
		FLT_NONE,
		FLT_RESET_VALID,
		FLT_AW_UNSTABLE,
		FLT_W_UNSTABLE,
		FLT_AR_UNSTABLE,
		FLT_B_UNSTABLE,
		FLT_R_UNSTABLE,
		FLT_EXOKAY,
		FLT_B_NOREQ,
		FLT_R_NOREQ,
		FLT_OVERFLOW,
		FLT_AW_STALL,
		FLT_W_STALL,
		FLT_AR_STALL,
		FLT_B_STALL,
		FLT_R_STALL,
		FLT_WR_DELAY,
		FLT_RD_DELAY
	} fault_code_e;

endpackage

// ==== hdl/axil_monitor_top.sv ====
// AXI4-Lite passive monitor top: counts, rule checks, watchdogs and fault log
`timescale 1ns/1ps

module axil_monitor_top
	import axil_bus_pkg::*, axil_mon_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_axi_reset_n,
	input  axil_bus_t   i_bus,
	output mon_counts_t o_counts,
	output logic        o_fault,
	output fault_code_e o_fault_code,
	output logic [7:0]  o_fault_count
);

	mon_counts_t   counts;
	logic          overflow;
	rule_faults_t  chk_faults;
	rule_faults_t  log_faults;
	stall_faults_t stall_faults;

	// Outstanding counts feed both checkers
	axil_txn_counter axil_txn_counter_inst (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_bus         (i_bus),
		.o_counts      (counts),
		.o_overflow    (overflow)
	);

	axil_rule_check axil_rule_check_inst (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_bus         (i_bus),
		.i_counts      (counts),
		.o_rule_faults (chk_faults)
	);

	axil_stall_watch axil_stall_watch_inst (
		.i_clk          (i_clk),
		.i_axi_reset_n  (i_axi_reset_n),
		.i_bus          (i_bus),
		.i_counts       (counts),
		.o_stall_faults (stall_faults)
	);

	// Overflow rides in the rule group
	always_comb
	begin
		log_faults          = chk_faults;
		log_faults.overflow = overflow;
	end

	axil_fault_log axil_fault_log_inst (
		.i_clk          (i_clk),
		.i_axi_reset_n  (i_axi_reset_n),
		.i_rule_faults  (log_faults),
		.i_stall_faults (stall_faults),
		.o_fault        (o_fault),
		.o_fault_code   (o_fault_code),
		.o_fault_count  (o_fault_count)
	);

	assign o_counts = counts;

endmodule

// ==== hdl/axil_rule_check.sv ====
// Protocol rule checker: reset VALIDs, payload stability, EXOKAY and orphan responses
`timescale 1ns/1ps

module axil_rule_check
	import axil_bus_pkg::*, axil_mon_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_axi_reset_n,
	input  axil_bus_t    i_bus,
	input  mon_counts_t  i_counts,
	output rule_faults_t o_rule_faults
);

	// Bus as it was last cycle
	axil_bus_t prev_q;
	// High in the first cycle after reset is released
	logic      in_reset_q;

	logic any_valid;

	// Stalled last cycle, now VALID dropped or payload moved
	function automatic logic unstable(
		input logic was_valid,
		input logic was_ready,
		input logic now_valid,
		input logic changed
	);
		return was_valid && !was_ready && (!now_valid || changed);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// History
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			prev_q     <= '0;
			in_reset_q <= 1'b1;
		end
		else
		begin
			prev_q     <= i_bus;
			in_reset_q <= 1'b0;
		end
	end

	assign any_valid = i_bus.aw.valid || i_bus.w.valid || i_bus.b.valid
		|| i_bus.ar.valid || i_bus.r.valid;

	////////////////////////////////////////////////////////////////////////////
	// Rule flags
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Every channel must come out of reset idle
		o_rule_faults.reset_valid = in_reset_q && any_valid;

		o_rule_faults.aw_unstable = unstable(prev_q.aw.valid, prev_q.aw.ready,
			i_bus.aw.valid, i_bus.aw.addr != prev_q.aw.addr);
		// Strobe counts as payload too
		o_rule_faults.w_unstable = unstable(prev_q.w.valid, prev_q.w.ready,
			i_bus.w.valid,
			(i_bus.w.data != prev_q.w.data) || (i_bus.w.strb != prev_q.w.strb));
		o_rule_faults.ar_unstable = unstable(prev_q.ar.valid, prev_q.ar.ready,
			i_bus.ar.valid, i_bus.ar.addr != prev_q.ar.addr);
		o_rule_faults.b_unstable = unstable(prev_q.b.valid, prev_q.b.ready,
			i_bus.b.valid, i_bus.b.resp != prev_q.b.resp);
		o_rule_faults.r_unstable = unstable(prev_q.r.valid, prev_q.r.ready,
			i_bus.r.valid,
			(i_bus.r.resp != prev_q.r.resp) || (i_bus.r.data != prev_q.r.data));

		// No exclusive access on AXI4-Lite
		o_rule_faults.exokay = (i_bus.b.valid && i_bus.b.resp == EXOKAY)
			|| (i_bus.r.valid && i_bus.r.resp == EXOKAY);

		// B needs both halves of a write accepted
		o_rule_faults.b_noreq = i_bus.b.valid && (i_counts.awr == '0 || i_counts.wr == '0);
		o_rule_faults.r_noreq = i_bus.r.valid && (i_counts.rd == '0);

		// Filled in from the counter at the top level
		o_rule_faults.overflow = 1'b0;
	end

endmodule

// ==== hdl/axil_stall_watch.sv ====
// Watchdogs for request stalls, response stalls and request-to-response delay
`timescale 1ns/1ps
`include "axil_mon_params.svh"

module axil_stall_watch
	import axil_bus_pkg::*, axil_mon_pkg::*;
(
	input  logic          i_clk,
	input  logic          i_axi_reset_n,
	input  axil_bus_t     i_bus,
	input  mon_counts_t   i_counts,
	output stall_faults_t o_stall_faults
);

	typedef logic [`MON_LGDEPTH-1:0] cnt_t;

	// Limits sized to the counter width
	localparam cnt_t MAXWAIT   = `MON_MAXWAIT;
	localparam cnt_t MAXRSTALL = `MON_MAXRSTALL;
	localparam cnt_t MAXDELAY  = `MON_MAXDELAY;

	cnt_t aw_cnt;
	cnt_t w_cnt;
	cnt_t ar_cnt;
	cnt_t b_cnt;
	cnt_t r_cnt;
	cnt_t wr_dly_cnt;
	cnt_t rd_dly_cnt;

	// Clear, else count up and hold at the limit so the flag stays high
	function automatic cnt_t step(input cnt_t cnt, input logic clr, input cnt_t lim);
		cnt_t res;
		res = cnt;
		if (clr)
			res = '0;
		else if (cnt < lim)
			res = cnt + 1'b1;
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Watchdog counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_cnt     <= '0;
			w_cnt      <= '0;
			ar_cnt     <= '0;
			b_cnt      <= '0;
			r_cnt      <= '0;
			wr_dly_cnt <= '0;
			rd_dly_cnt <= '0;
		end
		else
		begin
			// A pending B backs up the write side, so no AW or W stall then
			// AW ahead of W is the slave waiting for data, not a stall
			aw_cnt <= step(aw_cnt, !i_bus.aw.valid || i_bus.aw.ready || i_bus.b.valid
				|| (i_counts.awr >= i_counts.wr && !i_bus.w.valid), MAXWAIT);
			// Mirror of AW with the channels swapped
			w_cnt <= step(w_cnt, !i_bus.w.valid || i_bus.w.ready || i_bus.b.valid
				|| (i_counts.wr >= i_counts.awr && !i_bus.aw.valid), MAXWAIT);
			// Read address may wait behind a pending R
			ar_cnt <= step(ar_cnt, !i_bus.ar.valid || i_bus.ar.ready || i_bus.r.valid,
				MAXWAIT);
			// Responses held off by the master
			b_cnt <= step(b_cnt, !i_bus.b.valid || i_bus.b.ready, MAXRSTALL);
			r_cnt <= step(r_cnt, !i_bus.r.valid || i_bus.r.ready, MAXRSTALL);
			// Full write pair accepted and still no BVALID
			wr_dly_cnt <= step(wr_dly_cnt, i_bus.b.valid || i_counts.awr == '0
				|| i_counts.wr == '0, MAXDELAY);
			rd_dly_cnt <= step(rd_dly_cnt, i_bus.r.valid || i_counts.rd == '0, MAXDELAY);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Timeout flags
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		o_stall_faults.aw_stall = (aw_cnt >= MAXWAIT);
		o_stall_faults.w_stall  = (w_cnt >= MAXWAIT);
		o_stall_faults.ar_stall = (ar_cnt >= MAXWAIT);
		o_stall_faults.b_stall  = (b_cnt >= MAXRSTALL);
		o_stall_faults.r_stall  = (r_cnt >= MAXRSTALL);
		o_stall_faults.wr_delay = (wr_dly_cnt >= MAXDELAY);
		o_stall_faults.rd_delay = (rd_dly_cnt >= MAXDELAY);
	end

endmodule

// ==== hdl/axil_txn_counter.sv ====
// Outstanding transaction counter for AW, W and AR with overflow detection
`timescale 1ns/1ps
`include "axil_mon_params.svh"

module axil_txn_counter
	import axil_bus_pkg::*, axil_mon_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_axi_reset_n,
	input  axil_bus_t   i_bus,
	output mon_counts_t o_counts,
	output logic        o_overflow
);

	// Handshakes seen this cycle
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic ar_hs;
	logic r_hs;

	mon_counts_t counts_q;

	// Up on request, down on response, hold when both or neither
	function automatic logic [`MON_LGDEPTH-1:0] next_count(
		input logic [`MON_LGDEPTH-1:0] cnt,
		input logic                    inc,
		input logic                    dec
	);
		logic [`MON_LGDEPTH-1:0] res;
		res = cnt;
		if (inc && !dec)
			res = cnt + 1'b1;
		else if (dec && !inc)
			res = cnt - 1'b1;
		return res;
	endfunction

	assign aw_hs = i_bus.aw.valid && i_bus.aw.ready;
	assign w_hs  = i_bus.w.valid  && i_bus.w.ready;
	assign b_hs  = i_bus.b.valid  && i_bus.b.ready;
	assign ar_hs = i_bus.ar.valid && i_bus.ar.ready;
	assign r_hs  = i_bus.r.valid  && i_bus.r.ready;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			counts_q <= '0;
		else
		begin
			// One B retires both an address and a data beat
			counts_q.awr <= next_count(counts_q.awr, aw_hs, b_hs);
			counts_q.wr  <= next_count(counts_q.wr, w_hs, b_hs);
			counts_q.rd  <= next_count(counts_q.rd, ar_hs, r_hs);
		end
	end

	assign o_counts = counts_q;

	// All ones means the next request would wrap
	assign o_overflow = (&counts_q.awr) || (&counts_q.wr) || (&counts_q.rd);

endmodule

// ==== verif/tb_axil_monitor.sv ====
// AXI4-Lite monitor testbench that drives both sides of the link and checks counts and faults
`timescale 1ns/1ps
`include "axil_mon_params.svh"

module tb_axil_monitor
	import axil_bus_pkg::*, axil_mon_pkg::*;
();

	localparam int LGD = `MON_LGDEPTH;

	logic          clk;
	logic          axi_reset_n;
	axil_bus_t     bus;
	mon_counts_t   o_counts;
	logic          o_fault;
	fault_code_e   o_fault_code;
	logic [7:0]    o_fault_count;

	// Model state written only by the compare process
	mon_counts_t   exp_counts;
	logic          chk_en = 1'b0;
	logic [31:0]   seed = 32'h40ee;

	// Violations injected by the current test in priority order
	rule_faults_t  hit_rule;
	stall_faults_t hit_stall;

	axil_monitor_top axil_monitor_top_inst (
		.i_clk         (clk),
		.i_axi_reset_n (axi_reset_n),
		.i_bus         (bus),
		.o_counts      (o_counts),
		.o_fault       (o_fault),
		.o_fault_code  (o_fault_code),
		.o_fault_count (o_fault_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function logic [31:0] lcg_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_below(input int n);
		return int'(lcg_rand() % 32'(n));
	endfunction

	function automatic logic [`AXIL_AW-1:0] rand_addr();
		logic [31:0] rnd;
		rnd = lcg_rand();
		return rnd[`AXIL_AW-1:0];
	endfunction

	// Any response but EXOKAY
	function automatic axil_resp_e legal_resp();
		int pick;
		pick = rand_below(3);
		if (pick == 0)
			return OKAY;
		else if (pick == 1)
			return SLVERR;
		return DECERR;
	endfunction

	// Requests add one and responses retire one
	function automatic mon_counts_t ref_counts(input mon_counts_t c, input axil_bus_t b);
		mon_counts_t n;
		n.awr = c.awr + LGD'(b.aw.valid & b.aw.ready) - LGD'(b.b.valid & b.b.ready);
		n.wr  = c.wr + LGD'(b.w.valid & b.w.ready) - LGD'(b.b.valid & b.b.ready);
		n.rd  = c.rd + LGD'(b.ar.valid & b.ar.ready) - LGD'(b.r.valid & b.r.ready);
		return n;
	endfunction

	// Walk the codes in rank order so the first hit is the one logged
	function automatic fault_code_e first_fault(input logic [16:0] hits);
		fault_code_e code;
		code = FLT_RESET_VALID;
		for (int i = 16; i >= 0; i--)
		begin
			if (hits[i])
				return code;
			code = code.next();
		end
		return FLT_NONE;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %0h expected %0h",
				$time, name, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_fault(input int limit, output int waited);
		waited = 0;
		while (o_fault !== 1'b1)
		begin
			if (waited >= limit)
				abort_run("Timeout while waiting for o_fault to rise");
			next_cycle();
			waited++;
		end
	endtask

	task automatic expect_logged(input int n);
		check_val("o_fault", 32'(o_fault), 32'd1);
		check_val("o_fault_code", 32'(o_fault_code), 32'(first_fault({hit_rule, hit_stall})));
		check_val("o_fault_count", 32'(o_fault_count), 32'(n));
	endtask

	// Four cycles low and then one idle cycle so no VALID meets the first cycle out
	task automatic apply_reset();
		axi_reset_n = 1'b0;
		bus         = '0;
		hit_rule    = '0;
		hit_stall   = '0;
		repeat (4) next_cycle();
		axi_reset_n = 1'b1;
		chk_en      = 1'b1;
		check_val("o_fault", 32'(o_fault), 32'd0);
		check_val("o_fault_code", 32'(o_fault_code), 32'(FLT_NONE));
		check_val("o_fault_count", 32'(o_fault_count), 32'd0);
		next_cycle();
	endtask

	// Counts checked every cycle against the model
	always @(negedge clk)
	begin
		if (chk_en)
			check_val("o_counts", 32'(o_counts), 32'(exp_counts));
		if (!axi_reset_n)
			exp_counts = '0;
		else
			exp_counts = ref_counts(exp_counts, bus);
	end

	////////////////////////////////////////////////////////////////////////////
	// Legal traffic with one write and one read in flight at a time
	////////////////////////////////////////////////////////////////////////////

	task automatic random_traffic(input int n_wr, input int n_rd);
		int          wr_left, rd_left, guard;
		int          aw_dly, w_dly, b_dly, br_dly, ar_dly, r_dly, rr_dly;
		logic        aw_acc, w_acc, ar_acc, wr_busy, rd_busy, b_wait, r_wait;
		logic [31:0] rnd;
		wr_left = n_wr;
		rd_left = n_rd;
		guard   = 0;
		{aw_acc, w_acc, ar_acc, wr_busy, rd_busy, b_wait, r_wait} = '0;
		{aw_dly, w_dly, b_dly, br_dly, ar_dly, r_dly, rr_dly} = '0;
		while (wr_left > 0 || rd_left > 0)
		begin
			next_cycle();
			guard++;
			if (guard > 4000)
				abort_run("Timeout in random traffic, transactions did not finish");
			// AW and W accept on their own delays
			if (bus.aw.valid && bus.aw.ready)
			begin
				bus.aw.valid = 1'b0;
				bus.aw.ready = 1'b0;
				aw_acc = 1'b1;
			end
			else if (bus.aw.valid)
			begin
				if (aw_dly == 0)
					bus.aw.ready = 1'b1;
				else
					aw_dly--;
			end
			if (bus.w.valid && bus.w.ready)
			begin
				bus.w.valid = 1'b0;
				bus.w.ready = 1'b0;
				w_acc = 1'b1;
			end
			else if (bus.w.valid)
			begin
				if (w_dly == 0)
					bus.w.ready = 1'b1;
				else
					w_dly--;
			end
			// Write response side
			if (bus.b.valid && bus.b.ready)
			begin
				bus.b = '0;
				wr_busy = 1'b0;
				b_wait = 1'b0;
				wr_left--;
			end
			else if (bus.b.valid)
			begin
				if (br_dly == 0)
					bus.b.ready = 1'b1;
				else
					br_dly--;
			end
			else if (b_wait)
			begin
				if (b_dly == 0)
				begin
					bus.b.valid = 1'b1;
					bus.b.resp = legal_resp();
					br_dly = rand_below(8);
				end
				else
					b_dly--;
			end
			else if (wr_busy && aw_acc && w_acc)
			begin
				b_wait = 1'b1;
				aw_acc = 1'b0;
				w_acc = 1'b0;
				b_dly = rand_below(8);
			end
			else if (!wr_busy && wr_left > 0 && rand_below(2) == 0)
			begin
				wr_busy = 1'b1;
				bus.aw.valid = 1'b1;
				bus.aw.addr = rand_addr();
				bus.w.valid = 1'b1;
				bus.w.data = lcg_rand();
				rnd = lcg_rand();
				bus.w.strb = rnd[`AXIL_DW/8-1:0];
				aw_dly = rand_below(8);
				w_dly = rand_below(8);
			end
			// Read side runs alongside the write
			if (bus.ar.valid && bus.ar.ready)
			begin
				bus.ar.valid = 1'b0;
				bus.ar.ready = 1'b0;
				ar_acc = 1'b1;
			end
			else if (bus.ar.valid)
			begin
				if (ar_dly == 0)
					bus.ar.ready = 1'b1;
				else
					ar_dly--;
			end
			if (bus.r.valid && bus.r.ready)
			begin
				bus.r.valid = 1'b0;
				bus.r.ready = 1'b0;
				rd_busy = 1'b0;
				r_wait = 1'b0;
				rd_left--;
			end
			else if (bus.r.valid)
			begin
				if (rr_dly == 0)
					bus.r.ready = 1'b1;
				else
					rr_dly--;
			end
			else if (r_wait)
			begin
				if (r_dly == 0)
				begin
					bus.r.valid = 1'b1;
					bus.r.resp = legal_resp();
					bus.r.data = lcg_rand();
					rr_dly = rand_below(8);
				end
				else
					r_dly--;
			end
			else if (ar_acc)
			begin
				r_wait = 1'b1;
				ar_acc = 1'b0;
				r_dly = rand_below(8);
			end
			else if (!rd_busy && rd_left > 0 && rand_below(2) == 0)
			begin
				rd_busy = 1'b1;
				bus.ar.valid = 1'b1;
				bus.ar.addr = rand_addr();
				ar_dly = rand_below(8);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int waited;
		axi_reset_n = 1'b0;
		bus         = '0;
		apply_reset();

		// Legal traffic raises nothing
		random_traffic(20, 20);
		next_cycle();
		check_val("o_fault", 32'(o_fault), 32'd0);

		// AWADDR moves while stalled
		apply_reset();
		bus.aw.valid = 1'b1;
		bus.aw.addr  = rand_addr();
		next_cycle();
		bus.aw.addr  = ~bus.aw.addr;
		hit_rule.aw_unstable = 1'b1;
		check_val("o_fault", 32'(o_fault), 32'd0);
		next_cycle();
		expect_logged(1);

		// B with nothing outstanding
		apply_reset();
		bus.b.valid = 1'b1;
		bus.b.resp  = OKAY;
		hit_rule.b_noreq = 1'b1;
		next_cycle();
		expect_logged(1);

		// R held off by the master
		apply_reset();
		bus.ar.valid = 1'b1;
		bus.ar.ready = 1'b1;
		bus.ar.addr  = rand_addr();
		next_cycle();
		bus.ar.valid = 1'b0;
		bus.ar.ready = 1'b0;
		bus.r.valid  = 1'b1;
		bus.r.data   = lcg_rand();
		hit_stall.r_stall = 1'b1;
		wait_fault(40, waited);
		check_val("r stall cycles", 32'(waited), 32'(`MON_MAXRSTALL + 1));
		expect_logged(1);

		// EXOKAY on B and then an AW change that still logs but keeps the first code
		apply_reset();
		bus.aw = '{valid: 1'b1, ready: 1'b1, addr: rand_addr()};
		bus.w.valid = 1'b1;
		bus.w.ready = 1'b1;
		bus.w.data  = lcg_rand();
		next_cycle();
		bus.aw = '0;
		bus.w  = '0;
		bus.b  = '{valid: 1'b1, ready: 1'b1, resp: EXOKAY};
		hit_rule.exokay = 1'b1;
		next_cycle();
		bus.b = '0;
		bus.aw.valid = 1'b1;
		bus.aw.addr  = rand_addr();
		expect_logged(1);
		next_cycle();
		bus.aw.addr  = ~bus.aw.addr;
		bus.aw.ready = 1'b1;
		next_cycle();
		bus.aw = '0;
		next_cycle();
		expect_logged(2);
		repeat (2) next_cycle();
		expect_logged(2);

		// Reads pile up to all ones while a parked R keeps the delay watchdog quiet
		apply_reset();
		for (int c = 1; c <= 16; c++)
		begin
			bus.ar.valid = (c <= 15);
			bus.ar.ready = (c <= 15);
			bus.ar.addr  = rand_addr();
			if (c == 5)
			begin
				bus.r.valid = 1'b1;
				bus.r.data  = lcg_rand();
				bus.r.resp  = OKAY;
			end
			check_val("o_fault", 32'(o_fault), 32'd0);
			next_cycle();
		end
		hit_rule.overflow = 1'b1;
		check_val("o_counts.rd", 32'(o_counts.rd), 32'd15);
		expect_logged(1);
		apply_reset();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/axil_bus_pkg.sv
hdl/axil_mon_pkg.sv
hdl/axil_txn_counter.sv
hdl/axil_stall_watch.sv
hdl/axil_rule_check.sv
hdl/axil_fault_log.sv
hdl/axil_monitor_top.sv
verif/tb_axil_monitor.sv
